// ==== hw/interp_pkg.sv ====
`default_nettype none

package interp_pkg;

    ////////////////////////////////////////
    // widths

    localparam int SAMPLE_W = 24;   // one input channel, two's complement
    localparam int COEF_W   = 10;   // one weight, unsigned
    localparam int ACC_W    = 34;   // one output channel, signed, no rounding

    ////////////////////////////////////////
    // output rate

    // clocks per output frame
    localparam int OUT_PERIOD = 512;
    localparam int DIV_W      = $clog2(OUT_PERIOD);   // divider width, 9 bits

    // largest weight, also the sum of both weights
    localparam logic [COEF_W-1:0] PHASE_MAX = COEF_W'(OUT_PERIOD - 1);

    ////////////////////////////////////////
    // frame and weight types

    // one stereo input frame, 48 bits
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] left;
        logic signed [SAMPLE_W-1:0] right;
    } stereo_t;

    // history snapshot, older frame in the upper half
    typedef struct packed {
        stereo_t older;
        stereo_t newer;
    } pair_t;

    // weight pair, w_old + w_new == PHASE_MAX
    typedef struct packed {
        logic [COEF_W-1:0] w_old;   // weight of older frame
        logic [COEF_W-1:0] w_new;   // weight of newer frame
    } coef_t;

    // one stereo output frame, 68 bits
    typedef struct packed {
        logic signed [ACC_W-1:0] left;
        logic signed [ACC_W-1:0] right;
    } wide_stereo_t;

endpackage

`default_nettype wire

// ==== hw/phase_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module phase_tracker (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  logic              in_strobe,     // new input frame this cycle
    output logic              tick,          // output frame due
    output interp_pkg::coef_t coef,          // weights for the datapath
    output logic              coef_valid     // one cycle after tick
);

    logic [interp_pkg::DIV_W-1:0]  div_cnt;  // clocks into current output period
    logic [interp_pkg::COEF_W-1:0] phase;    // clocks since newest input
    logic [interp_pkg::COEF_W-1:0] w_new;    // phase seen by a tick this cycle

    ////////////////////////////////////////
    // output tick divider

    // counts only with run high, restarts from zero when run drops
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;       // wraps after OUT_PERIOD clocks
        end
    end

    // last clock of the period, 512th clock with run high
    assign tick = run && (&div_cnt);

    ////////////////////////////////////////
    // input phase counter

    // cleared by each strobe, sticks at PHASE_MAX on long gaps
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
        end else if (in_strobe) begin
            phase <= '0;
        end else if (phase != interp_pkg::PHASE_MAX) begin
            phase <= phase + 1'b1;
        end
    end

    // strobe wins over tick
    // coincident strobe means the newest frame is brand new, phase 0
    assign w_new = in_strobe ? '0 : phase;

    ////////////////////////////////////////
    // weight register

    always_ff @(posedge clk) begin
        if (rst) begin
            coef_valid <= 1'b0;
            coef.w_old <= interp_pkg::PHASE_MAX;   // all weight on older, sum holds
            coef.w_new <= '0;
        end else begin
            coef_valid <= tick;                    // single-cycle pulse
            if (tick) begin
                coef.w_new <= w_new;
                coef.w_old <= interp_pkg::PHASE_MAX - w_new;   // never negative
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/sample_history.sv ====
`timescale 1ns/100ps
`default_nettype none

module sample_history (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_strobe,   // shift in a frame
    input  interp_pkg::stereo_t in_frame,    // valid with in_strobe
    input  logic                tick,        // take a snapshot
    output interp_pkg::pair_t   pair         // stable from the cycle after tick
);

    interp_pkg::pair_t hist;        // live two-deep history
    interp_pkg::pair_t hist_next;   // history after this cycle's strobe

    ////////////////////////////////////////
    // shift pair

    // newer moves down to older, in_frame becomes newer
    always_comb begin
        hist_next = hist;
        if (in_strobe) begin
            hist_next.older = hist.newer;
            hist_next.newer = in_frame;
        end
    end

    // history starts as silence on both taps
    always_ff @(posedge clk) begin
        if (rst) begin
            hist <= '0;
        end else begin
            hist <= hist_next;
        end
    end

    ////////////////////////////////////////
    // snapshot

    // taken from hist_next so a strobe in the tick cycle is already in
    // later strobes leave the snapshot alone until the next tick
    always_ff @(posedge clk) begin
        if (tick) begin
            pair <= hist_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/interp_mac.sv ====
`timescale 1ns/100ps
`default_nettype none

module interp_mac (
    input  logic                     clk,
    input  logic                     rst,
    input  interp_pkg::coef_t        coef,         // weights, valid with coef_valid
    input  logic                     coef_valid,
    input  interp_pkg::pair_t        pair,         // older and newer frames
    output logic                     out_valid,    // two cycles after coef_valid
    output interp_pkg::wide_stereo_t out_frame     // held until next result
);

    // stage one, weighted taps per channel
    interp_pkg::wide_stereo_t prod_old;   // older * w_old
    interp_pkg::wide_stereo_t prod_new;   // newer * w_new
    logic                     s1_valid;

    ////////////////////////////////////////
    // signed sample times unsigned weight

    function automatic logic signed [interp_pkg::ACC_W-1:0] weigh(
        input logic signed [interp_pkg::SAMPLE_W-1:0] sample,
        input logic        [interp_pkg::COEF_W-1:0]   weight
    );
        logic signed [interp_pkg::COEF_W:0]                      weight_s;
        logic signed [interp_pkg::SAMPLE_W+interp_pkg::COEF_W:0] full;
        weight_s = $signed({1'b0, weight});   // zero-extend, stays positive
        full     = sample * weight_s;
        // 24 x 10 bit product fits in ACC_W, top bit is only sign copy
        return full[interp_pkg::ACC_W-1:0];
    endfunction

    ////////////////////////////////////////
    // stage one, four products

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= coef_valid;
        end
    end

    // products load only with a fresh weight pair
    always_ff @(posedge clk) begin
        if (coef_valid) begin
            prod_old.left  <= weigh(pair.older.left,  coef.w_old);
            prod_old.right <= weigh(pair.older.right, coef.w_old);
            prod_new.left  <= weigh(pair.newer.left,  coef.w_new);
            prod_new.right <= weigh(pair.newer.right, coef.w_new);
        end
    end

    ////////////////////////////////////////
    // stage two, per-channel sum

    // weights sum to 511, so |sum| <= 2^23 * 511, no overflow in ACC_W
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_frame <= '0;
        end else begin
            out_valid <= s1_valid;                            // one-cycle pulse
            if (s1_valid) begin
                out_frame.left  <= prod_old.left  + prod_new.left;
                out_frame.right <= prod_old.right + prod_new.right;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/interp_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module interp_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     run,         // enables the output rate
    input  logic                     in_strobe,   // input frame strobe
    input  interp_pkg::stereo_t      in_frame,
    output logic                     out_valid,   // 3 cycles after internal tick
    output interp_pkg::wide_stereo_t out_frame
);

    logic              tick;         // output period end
    interp_pkg::coef_t coef;         // weight pair
    logic              coef_valid;   // weights and pair ready
    interp_pkg::pair_t pair;         // history snapshot

    ////////////////////////////////////////
    // rate and weights

    phase_tracker i_phase_tracker (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .in_strobe  (in_strobe),
        .tick       (tick),
        .coef       (coef),
        .coef_valid (coef_valid)
    );

    ////////////////////////////////////////
    // input frames

    sample_history i_sample_history (
        .clk        (clk),
        .rst        (rst),
        .in_strobe  (in_strobe),
        .in_frame   (in_frame),
        .tick       (tick),
        .pair       (pair)        // lines up with coef_valid
    );

    ////////////////////////////////////////
    // two-tap datapath

    interp_mac i_interp_mac (
        .clk        (clk),
        .rst        (rst),
        .coef       (coef),
        .coef_valid (coef_valid),
        .pair       (pair),
        .out_valid  (out_valid),
        .out_frame  (out_frame)
    );

endmodule

`default_nettype wire

// ==== tests/interp_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module interp_props (
    input logic              clk,
    input logic              rst,
    input logic              run,
    input logic              tick,
    input interp_pkg::coef_t coef,
    input logic              coef_valid,
    input logic              out_valid,
    input logic              mac_side      // high when out_valid is the real one
);

    int fail_count = 0;   // summed by the testbench at the end
    int run_clocks;       // clocks with run high since it last rose

    ////////////////////////////////////////
    // weights

    // 11 bits so a wrong pair cannot wrap back to 511
    weight_sum: assert property (@(posedge clk) disable iff (rst)
        (11'(coef.w_old) + 11'(coef.w_new)) == 11'(interp_pkg::PHASE_MAX))
    else begin
        $error("weight pair does not sum to PHASE_MAX");
        fail_count++;
    end

    coef_pulse: assert property (@(posedge clk) disable iff (rst)
        coef_valid |=> !coef_valid)
    else begin
        $error("coef_valid high for more than one cycle");
        fail_count++;
    end

    ////////////////////////////////////////
    // pipeline and rate

    // two register stages from weights to output
    mac_latency: assert property (@(posedge clk) disable iff (rst)
        mac_side |-> (out_valid == $past(coef_valid, 2)))
    else begin
        $error("out_valid does not follow coef_valid by two cycles");
        fail_count++;
    end

    // independent count of the run-high stretch
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            run_clocks <= 0;
        end else begin
            run_clocks <= run_clocks + 1;
        end
    end

    // tick only with run high, on the last clock of each full period since run rose
    tick_needs_run: assert property (@(posedge clk) disable iff (rst)
        tick |-> run &&
            ((run_clocks % interp_pkg::OUT_PERIOD) == interp_pkg::OUT_PERIOD - 1))
    else begin
        $error("tick while run is low or off the period since run rose");
        fail_count++;
    end

endmodule

// tracker side has no out_valid, mac side has no run or tick
bind phase_tracker interp_props i_props (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .tick       (tick),
    .coef       (coef),
    .coef_valid (coef_valid),
    .out_valid  (1'b0),
    .mac_side   (1'b0)
);

bind interp_mac interp_props i_props (
    .clk        (clk),
    .rst        (rst),
    .run        (1'b1),
    .tick       (1'b0),
    .coef       (coef),
    .coef_valid (coef_valid),
    .out_valid  (out_valid),
    .mac_side   (1'b1)
);

`default_nettype wire

// ==== tests/interp_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module interp_tb;

    localparam int PERIOD     = interp_pkg::OUT_PERIOD;
    localparam int PHASE_TOP  = interp_pkg::OUT_PERIOD - 1;   // largest weight
    localparam int LATENCY    = 3;                            // tick to out_valid
    localparam int MAX_CYCLES = 40 * PERIOD + 1000;

    // how input strobes are spaced
    localparam int GAP_SLOW    = 0;   // mostly 100..900 clocks
    localparam int GAP_FAST    = 1;   // 1..64 clocks
    localparam int GAP_ON_TICK = 2;   // only in the tick cycle

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     run;
    logic                     in_strobe;
    interp_pkg::stereo_t      in_frame;
    logic                     out_valid;
    interp_pkg::wide_stereo_t out_frame;

    // stimulus state
    logic [31:0] lfsr;
    logic        run_req;          // run level for the next cycles
    logic        extreme;          // full-scale samples only
    int          gap_mode;
    int          gap_left;
    int          cycle;            // negedge count since reset release
    int          restart_cycle;    // cycle run last went high, -1 once seen

    // reference model
    int                  m_div;
    int                  m_phase;
    interp_pkg::stereo_t m_older;
    interp_pkg::stereo_t m_newer;
    int                  due_q[$];
    longint              exp_left_q[$];
    longint              exp_right_q[$];

    // bookkeeping
    int errors;
    int checked;
    int outputs;
    int coincide;                  // strobes that hit a tick
    int assert_fails;
    int total_cycles = 0;

    interp_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .in_strobe (in_strobe),
        .in_frame  (in_frame),
        .out_valid (out_valid),
        .out_frame (out_frame)
    );

    always #50 clk = ~clk;   // 100 ns period

    // hard stop in case outputs never come
    always @(posedge clk) begin
        total_cycles <= total_cycles + 1;
        if (total_cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the test sequence never finished", total_cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // random numbers

    // x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);            // one step per bit
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic next_gap();
        logic [31:0] r;
        if (gap_mode == GAP_FAST) begin
            draw(6, r);
            gap_left = 1 + int'(r);
        end else begin
            draw(3, r);
            if (r == 0) begin                  // one in eight, short burst
                draw(4, r);
                gap_left = 1 + int'(r);
            end else begin
                draw(10, r);
                gap_left = 100 + int'(r % 801);
            end
        end
    endtask

    task automatic draw_sample(output logic signed [interp_pkg::SAMPLE_W-1:0] s);
        logic [31:0] r;
        if (extreme) begin
            draw(1, r);
            s = r[0] ? 24'sh7fffff : 24'sh800000;   // most positive or most negative
        end else begin
            draw(24, r);
            s = r[23:0];
        end
    endtask

    ////////////////////////////////////////
    // reference model

    // older * (511 - phase) + newer * phase, full precision
    function automatic longint mix(
        input logic signed [interp_pkg::SAMPLE_W-1:0] older,
        input logic signed [interp_pkg::SAMPLE_W-1:0] newer,
        input int                                     w_new
    );
        return longint'(older) * (PHASE_TOP - w_new) + longint'(newer) * w_new;
    endfunction

    // advance the model through the cycle just driven
    task automatic model_step(input logic strobe, input interp_pkg::stereo_t frame);
        logic tick_now;
        int   w_new;
        tick_now = run && (m_div == PERIOD - 1);
        if (strobe) begin                      // strobe lands before the snapshot
            m_older = m_newer;
            m_newer = frame;
        end
        if (tick_now) begin
            w_new = strobe ? 0 : m_phase;
            if (strobe) begin
                coincide++;
            end
            due_q.push_back(cycle + LATENCY);
            exp_left_q.push_back(mix(m_older.left, m_newer.left, w_new));
            exp_right_q.push_back(mix(m_older.right, m_newer.right, w_new));
        end
        if (strobe) begin
            m_phase = 0;
        end else if (m_phase < PHASE_TOP) begin
            m_phase++;                         // saturates at 511
        end
        m_div = run ? (m_div + 1) % PERIOD : 0;
    endtask

    ////////////////////////////////////////
    // checking

    task automatic check_value(input string name, input longint expected, input longint actual);
        checked++;
        if (expected !== actual) begin
            errors++;
            $display("** Error at %0d ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error at %0d ns: %s", $time, what);
    endtask

    task automatic compare_outputs();
        while (due_q.size() > 0 && due_q[0] < cycle) begin   // overdue frames
            report_failure($sformatf("no out_valid for the frame due in cycle %0d", due_q[0]));
            void'(due_q.pop_front());
            void'(exp_left_q.pop_front());
            void'(exp_right_q.pop_front());
        end
        if (out_valid) begin
            if (due_q.size() == 0 || due_q[0] != cycle) begin
                report_failure($sformatf("out_valid in cycle %0d with no frame due", cycle));
            end else begin
                check_value("out_frame.left", exp_left_q[0], longint'($signed(out_frame.left)));
                check_value("out_frame.right", exp_right_q[0],
                            longint'($signed(out_frame.right)));
                void'(due_q.pop_front());
                void'(exp_left_q.pop_front());
                void'(exp_right_q.pop_front());
                outputs++;
            end
            if (restart_cycle >= 0) begin      // first output after run went high
                check_value("run to out_valid cycles", longint'(PERIOD + LATENCY - 1),
                            longint'(cycle - restart_cycle));
                restart_cycle = -1;
            end
        end
    endtask

    ////////////////////////////////////////
    // per-cycle driver

    // called right after a falling edge
    task automatic cycle_body();
        logic                strobe;
        interp_pkg::stereo_t frame;
        cycle++;
        compare_outputs();                     // outputs settled since the rising edge
        if (run_req && !run) begin
            restart_cycle = cycle;
        end
        run = run_req;
        if (gap_mode == GAP_ON_TICK) begin
            strobe = run && (m_div == PERIOD - 1);
        end else begin
            gap_left--;
            strobe = (gap_left <= 0);
            if (strobe) begin
                next_gap();
            end
        end
        frame = in_frame;                      // held while idle
        if (strobe) begin
            draw_sample(frame.left);
            draw_sample(frame.right);
        end
        in_strobe = strobe;
        in_frame  = frame;
        model_step(strobe, frame);
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            cycle_body();
        end
    endtask

    ////////////////////////////////////////
    // test sequence

    initial begin
        rst           = 1'b1;
        run           = 1'b0;
        in_strobe     = 1'b0;
        in_frame      = '0;
        run_req       = 1'b0;
        extreme       = 1'b0;
        lfsr          = 32'h6997;
        gap_mode      = GAP_SLOW;
        gap_left      = 50;
        cycle         = 0;
        restart_cycle = -1;
        m_div         = 0;
        m_phase       = 0;
        m_older       = '0;
        m_newer       = '0;
        errors        = 0;
        checked       = 0;
        outputs       = 0;
        coincide      = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cycle_body();

        run_cycles(300);                       // run low, inputs only, no output
        run_req = 1'b1;
        run_cycles(12 * PERIOD);               // slow inputs, phase often saturates
        gap_mode = GAP_FAST;
        run_cycles(6 * PERIOD);                // several strobes per period
        gap_mode = GAP_ON_TICK;
        run_cycles(4 * PERIOD);                // strobe and tick together
        gap_mode = GAP_SLOW;
        extreme  = 1'b1;
        run_cycles(6 * PERIOD);                // full-scale samples
        extreme  = 1'b0;
        run_cycles(200);
        run_req = 1'b0;                        // drop run mid-period
        run_cycles(40);
        run_req = 1'b1;
        run_cycles(3 * PERIOD);
        run_req = 1'b0;
        run_cycles(10);                        // drain the pipeline

        if (due_q.size() != 0) begin
            report_failure($sformatf("%0d expected frames never came out", due_q.size()));
        end
        if (coincide == 0) begin
            report_failure("no input strobe ever fell in a tick cycle");
        end
        assert_fails = i_dut.i_phase_tracker.i_props.fail_count +
                       i_dut.i_interp_mac.i_props.fail_count;
        if (assert_fails != 0) begin
            report_failure($sformatf("%0d assertion failures", assert_fails));
        end
        $display("%0d errors, %0d values checked over %0d outputs", errors, checked, outputs);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/interp_pkg.sv
hw/phase_tracker.sv
hw/sample_history.sv
hw/interp_mac.sv
hw/interp_top.sv
tests/interp_props.sv
tests/interp_tb.sv

// ==== Makefile ====
# Verilator build and run of the interpolator testbench

SRCS := $(filter-out +%,$(shell cat sources.f))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vinterp_tb: sources.f $(SRCS)
	verilator --binary --assert --top-module interp_tb -f sources.f -Mdir obj_dir -o Vinterp_tb

# assertion errors must not stop the run before the summary
run: obj_dir/Vinterp_tb
	./obj_dir/Vinterp_tb +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "^SIMULATION PASSED$$" sim.log; then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
